// File: src/fdc_pkg.sv
/*
 * Controller package for the WD279x-style sector engine.
 * Holds command codes, host register addresses, status bit positions
 * and the timing constants of the emulated clock domain.
 */
`default_nettype none

package fdc_pkg;

	// Base codes of the supported commands
	// Bit 4 is multiple-sector, bit 3 the side, bit 2 the settle delay and bit 1 side compare
	localparam logic [7:0] cmd_read_sector  = 8'h80;
	localparam logic [7:0] cmd_write_sector = 8'hA0;
	localparam logic [7:0] cmd_force_int    = 8'hD0;

	// Host register map
	localparam logic [1:0] addr_cmd_status = 2'd0;
	localparam logic [1:0] addr_track      = 2'd1;
	localparam logic [1:0] addr_sector     = 2'd2;
	localparam logic [1:0] addr_data       = 2'd3;

	// Bit positions in the Type II status byte
	localparam int st_busy     = 0;
	localparam int st_drq      = 1;
	localparam int st_lost     = 2;
	localparam int st_crc      = 3;
	localparam int st_rnf      = 4;
	localparam int st_rtype    = 5;
	localparam int st_wprot    = 6;
	localparam int st_notready = 7;

	// Timing, scaled down so that whole revolutions fit in a short run
	localparam int ms_cycles   = 40;
	localparam int byte_cycles = 6;
	localparam int settle_ms   = 15;
	localparam int index_limit = 5;

endpackage

`default_nettype wire

// File: src/disk_pkg.sv
/*
 * Disk-format package for the emulated drive.
 * ID field layout, track geometry and the rule for the data pattern.
 */
`default_nettype none

package disk_pkg;

	// Positions inside the six-byte ID field
	localparam int id_track  = 0;
	localparam int id_side   = 1;
	localparam int id_sector = 2;
	localparam int id_length = 3;
	localparam int id_crc1   = 4;
	localparam int id_crc2   = 5;

	// Track geometry, sectors are numbered from 1
	localparam int sectors_per_track = 5;
	localparam int sector_bytes      = 16;
	localparam int gap_bytes         = 8;

	// Byte k of sector s on track t is 16*s + k + t, kept to eight bits
	function automatic logic [7:0] pattern_byte(input logic [7:0] track,
		input logic [7:0] sector, input logic [7:0] k);
		return 8'(sector * 16 + k + track);
	endfunction

endpackage

`default_nettype wire

// File: src/fdc_timebase.sv
/*
 * Timebase for the controller.
 * Divides clk into a millisecond tick and the disk byte-rate strobe.
 */
`timescale 1ns/1ps
`default_nettype none

module fdc_timebase
	import fdc_pkg::*;
(
	input  logic clk,
	input  logic rst,
	output logic ms_tick,
	output logic byte_tick
);

	logic [$clog2(ms_cycles)-1:0]   ms_cnt;
	logic [$clog2(byte_cycles)-1:0] byte_cnt;

	// Millisecond divider, the tick is high on the last count
	always_ff @(posedge clk) begin
		if (rst) begin
			ms_cnt  <= '0;
			ms_tick <= 1'b0;
		end else if (int'(ms_cnt) == ms_cycles - 1) begin
			ms_cnt  <= '0;
			ms_tick <= 1'b1;
		end else begin
			ms_cnt  <= ms_cnt + 1'b1;
			ms_tick <= 1'b0;
		end
	end

	// Byte-rate divider, one strobe per byte cell on the disk
	always_ff @(posedge clk) begin
		if (rst) begin
			byte_cnt  <= '0;
			byte_tick <= 1'b0;
		end else if (int'(byte_cnt) == byte_cycles - 1) begin
			byte_cnt  <= '0;
			byte_tick <= 1'b1;
		end else begin
			byte_cnt  <= byte_cnt + 1'b1;
			byte_tick <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// File: src/fdc_host_regs.sv
/*
 * Host register file of the controller.
 * Decodes byte-wide bus accesses into command, track and sector writes,
 * the force interrupt strobe and the data-read strobe.
 */
`timescale 1ns/1ps
`default_nettype none

module fdc_host_regs
	import fdc_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       cs,
	input  logic       we,
	input  logic [1:0] addr,
	input  logic [7:0] wdata,
	output logic [7:0] rdata,
	input  logic [7:0] status,
	input  logic [7:0] data,
	input  logic [7:0] sector_next,
	input  logic       sector_write,
	output logic [7:0] command,
	output logic       command_start,
	output logic       interrupt,
	output logic       read_data,
	output logic [7:0] reg_track,
	output logic [7:0] reg_sector
);

	logic bus_write;
	logic is_force_int;

	assign bus_write    = cs && we;
	// Any code in the Dx group counts as force interrupt
	assign is_force_int = wdata[7:4] == cmd_force_int[7:4];

	// Strobes follow the bus cycle directly so the engine sees them at the write edge
	assign command_start = bus_write && addr == addr_cmd_status && !is_force_int;
	assign interrupt     = bus_write && addr == addr_cmd_status && is_force_int;
	assign read_data     = cs && !we && addr == addr_data;

	always_ff @(posedge clk) begin
		if (rst) begin
			command    <= 8'h00;
			reg_track  <= 8'h00;
			reg_sector <= 8'h00;
		end else begin
			// Force interrupt leaves the last command in place for the status view
			if (command_start)
				command <= wdata;
			if (bus_write && addr == addr_track)
				reg_track <= wdata;
			// The engine advancing the sector wins over a host write in the same cycle
			if (sector_write)
				reg_sector <= sector_next;
			else if (bus_write && addr == addr_sector)
				reg_sector <= wdata;
		end
	end

	// Read mux, host writes to the data register have no effect since writes carry no data
	always_comb begin
		case (addr)
			addr_cmd_status: rdata = status;
			addr_track:      rdata = reg_track;
			addr_sector:     rdata = reg_sector;
			default:         rdata = data;
		endcase
	end

endmodule

`default_nettype wire

// File: src/fdc_sector_cmd.sv
/*
 * Type II sector engine.
 * Checks ready, loads the head, waits the settle delay, searches for the ID
 * field and streams sector bytes with DRQ, or ends a write at the ID field.
 */
`timescale 1ns/1ps
`default_nettype none

module fdc_sector_cmd
	import fdc_pkg::*;
	import disk_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       ms_tick,
	input  logic       byte_tick,
	input  logic       interrupt,
	input  logic       command_start,
	input  logic       read_data,
	input  logic [7:0] command,
	input  logic       data_valid,
	input  logic [7:0] fdd_data,
	output logic [7:0] data,
	input  logic       index_n,
	input  logic       ready_n,
	input  logic       wprot_n,
	output logic       sso,
	output logic       hld,
	output logic [7:0] status,
	output logic       intrq,
	output logic       drq,
	input  logic [7:0] reg_track,
	input  logic [7:0] reg_sector,
	output logic [7:0] sector_next,
	output logic       sector_write,
	input  logic [7:0] sec_id [6]
);

	typedef enum logic [2:0] {
		state_idle,
		state_prepare,
		state_settle,
		state_search,
		state_read
	} state_t;

	state_t     state;
	logic       busy;
	logic       is_write;
	logic       id_match;
	logic       lost;
	logic       rnf;
	logic       wprot;
	logic       notready;
	logic [3:0] wait_count;
	logic [2:0] index_count;
	logic       last_index;

	assign busy     = state != state_idle;
	assign is_write = command[7:5] == cmd_write_sector[7:5];
	// Side is only compared when bit 1 of the command asks for it
	assign id_match = sec_id[id_track] == reg_track && sec_id[id_sector] == reg_sector &&
		(!command[1] || sec_id[id_side][0] == command[3]);

	always_comb begin
		status = 8'h00;
		status[st_busy]     = busy;
		status[st_drq]      = drq;
		status[st_lost]     = lost;
		// CRC and deleted marks are not modelled, so these two read as zero
		status[st_crc]      = 1'b0;
		status[st_rnf]      = rnf;
		status[st_rtype]    = 1'b0;
		status[st_wprot]    = wprot;
		status[st_notready] = notready;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state        <= state_idle;
			lost         <= 1'b0;
			rnf          <= 1'b0;
			wprot        <= 1'b0;
			notready     <= 1'b0;
			drq          <= 1'b0;
			intrq        <= 1'b0;
			hld          <= 1'b0;
			sso          <= 1'b0;
			sector_write <= 1'b0;
			wait_count   <= 4'd0;
			index_count  <= 3'd0;
			last_index   <= 1'b1;
		end else if (interrupt) begin
			// Force interrupt drops whatever runs and unloads the head
			state        <= state_idle;
			drq          <= 1'b0;
			intrq        <= 1'b1;
			hld          <= 1'b0;
			sector_write <= 1'b0;
		end else begin
			sector_write <= 1'b0;
			last_index   <= index_n;
			if (read_data)
				drq <= 1'b0;
			case (state)
				state_idle: begin
					if (command_start) begin
						intrq    <= 1'b0;
						lost     <= 1'b0;
						rnf      <= 1'b0;
						wprot    <= 1'b0;
						notready <= 1'b0;
						drq      <= 1'b0;
						state    <= state_prepare;
					end
				end
				state_prepare: begin
					// Anything outside the Type II group finishes at once
					if (command[7:6] != cmd_read_sector[7:6]) begin
						intrq <= 1'b1;
						state <= state_idle;
					end else if (ready_n) begin
						notready <= 1'b1;
						intrq    <= 1'b1;
						state    <= state_idle;
					end else begin
						hld        <= 1'b1;
						sso        <= command[3];
						wait_count <= command[2] ? 4'(settle_ms) : 4'd0;
						state      <= state_settle;
					end
				end
				state_settle: begin
					if (wait_count != 4'd0) begin
						if (ms_tick)
							wait_count <= wait_count - 4'd1;
					end else if (is_write && !wprot_n) begin
						wprot <= 1'b1;
						intrq <= 1'b1;
						state <= state_idle;
					end else if (!data_valid) begin
						// Search starts in a gap, so the first window seen is a whole one
						index_count <= 3'd0;
						state       <= state_search;
					end
				end
				state_search: begin
					if (last_index && !index_n)
						index_count <= index_count + 3'd1;
					if (index_count == 3'(index_limit)) begin
						rnf   <= 1'b1;
						drq   <= 1'b0;
						intrq <= 1'b1;
						state <= state_idle;
					end else if (data_valid && id_match) begin
						// Writes stop at the ID field, no data phase follows
						if (is_write) begin
							intrq <= 1'b1;
							state <= state_idle;
						end else begin
							state <= state_read;
						end
					end
				end
				state_read: begin
					if (data_valid) begin
						// A byte still waiting at the next strobe is overwritten
						if (byte_tick) begin
							if (drq && !read_data)
								lost <= 1'b1;
							drq  <= 1'b1;
							data <= fdd_data;
						end
					end else if (command[4]) begin
						sector_next  <= reg_sector + 8'd1;
						sector_write <= 1'b1;
						state        <= state_settle;
					end else if (!drq) begin
						// The command ends only once the last byte has been taken
						intrq <= 1'b1;
						state <= state_idle;
					end
				end
				default: state <= state_idle;
			endcase
		end
	end

endmodule

`default_nettype wire

// File: src/disk_stream.sv
/*
 * Emulated rotating track.
 * Steps through gap and sector windows of one revolution, pulses index
 * at its start and presents ID fields and pattern data for the head.
 */
`timescale 1ns/1ps
`default_nettype none

module disk_stream
	import disk_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       byte_tick,
	input  logic       ready_n,
	input  logic [7:0] head_track,
	input  logic       side,
	output logic       index_n,
	output logic       data_valid,
	output logic [7:0] sec_id [6],
	output logic [7:0] fdd_data
);

	// Each slot is a gap followed by the sector window
	localparam int slot_bytes = gap_bytes + sector_bytes;

	logic [$clog2(slot_bytes)-1:0]        byte_cnt;
	logic [$clog2(slot_bytes)-1:0]        nxt_byte;
	logic [$clog2(sectors_per_track)-1:0] sec_num;
	logic [$clog2(sectors_per_track)-1:0] nxt_sec;
	logic [7:0]                           nxt_offset;

	// Position one byte cell ahead
	always_comb begin
		nxt_byte = byte_cnt + 1'b1;
		nxt_sec  = sec_num;
		if (int'(byte_cnt) == slot_bytes - 1) begin
			nxt_byte = '0;
			if (int'(sec_num) == sectors_per_track - 1)
				nxt_sec = '0;
			else
				nxt_sec = sec_num + 1'b1;
		end
		nxt_offset = 8'(int'(nxt_byte) - gap_bytes);
	end

	// ID field of the current slot, it only changes inside the gap
	always_comb begin
		sec_id[id_track]  = head_track;
		sec_id[id_side]   = {7'd0, side};
		sec_id[id_sector] = 8'(sec_num) + 8'd1;
		sec_id[id_length] = 8'h00;
		// No CRC is computed, fixed filler stands in its place
		sec_id[id_crc1]   = 8'hA5;
		sec_id[id_crc2]   = 8'h5A;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			byte_cnt   <= '0;
			sec_num    <= '0;
			index_n    <= 1'b1;
			data_valid <= 1'b0;
		end else if (byte_tick) begin
			byte_cnt   <= nxt_byte;
			sec_num    <= nxt_sec;
			// Index hole passes during the first gap cell of the revolution
			index_n    <= !(nxt_sec == '0 && nxt_byte == '0);
			data_valid <= !ready_n && int'(nxt_byte) >= gap_bytes;
			fdd_data   <= pattern_byte(head_track, 8'(nxt_sec) + 8'd1, nxt_offset);
		end
	end

endmodule

`default_nettype wire

// File: src/fdc_top.sv
/*
 * Top level of the sector-command controller with its emulated drive.
 * Connects the host registers, timebase, sector engine and disk stream.
 */
`timescale 1ns/1ps
`default_nettype none

module fdc_top (
	input  logic       clk,
	input  logic       rst,
	input  logic       cs,
	input  logic       we,
	input  logic [1:0] addr,
	input  logic [7:0] wdata,
	output logic [7:0] rdata,
	input  logic       ready_n,
	input  logic       wprot_n,
	input  logic [7:0] head_track,
	output logic       intrq,
	output logic       drq,
	output logic       hld
);

	logic       ms_tick;
	logic       byte_tick;
	logic [7:0] status;
	logic [7:0] data;
	logic [7:0] sector_next;
	logic       sector_write;
	logic [7:0] command;
	logic       command_start;
	logic       interrupt;
	logic       read_data;
	logic [7:0] reg_track;
	logic [7:0] reg_sector;
	logic       sso;
	logic       index_n;
	logic       data_valid;
	logic [7:0] sec_id [6];
	logic [7:0] fdd_data;

	fdc_timebase u_timebase (
		.clk      (clk),
		.rst      (rst),
		.ms_tick  (ms_tick),
		.byte_tick(byte_tick)
	);

	fdc_host_regs u_regs (
		.clk          (clk),
		.rst          (rst),
		.cs           (cs),
		.we           (we),
		.addr         (addr),
		.wdata        (wdata),
		.rdata        (rdata),
		.status       (status),
		.data         (data),
		.sector_next  (sector_next),
		.sector_write (sector_write),
		.command      (command),
		.command_start(command_start),
		.interrupt    (interrupt),
		.read_data    (read_data),
		.reg_track    (reg_track),
		.reg_sector   (reg_sector)
	);

	fdc_sector_cmd u_sector (
		.clk          (clk),
		.rst          (rst),
		.ms_tick      (ms_tick),
		.byte_tick    (byte_tick),
		.interrupt    (interrupt),
		.command_start(command_start),
		.read_data    (read_data),
		.command      (command),
		.data_valid   (data_valid),
		.fdd_data     (fdd_data),
		.data         (data),
		.index_n      (index_n),
		.ready_n      (ready_n),
		.wprot_n      (wprot_n),
		.sso          (sso),
		.hld          (hld),
		.status       (status),
		.intrq        (intrq),
		.drq          (drq),
		.reg_track    (reg_track),
		.reg_sector   (reg_sector),
		.sector_next  (sector_next),
		.sector_write (sector_write),
		.sec_id       (sec_id)
	);

	// The drive reads the side that the engine selects
	disk_stream u_disk (
		.clk       (clk),
		.rst       (rst),
		.byte_tick (byte_tick),
		.ready_n   (ready_n),
		.head_track(head_track),
		.side      (sso),
		.index_n   (index_n),
		.data_valid(data_valid),
		.sec_id    (sec_id),
		.fdd_data  (fdd_data)
	);

endmodule

`default_nettype wire

// File: dv/fdc_props.sv
/*
 * Concurrent properties of the Type II sector engine.
 * Bound into every instance of the engine.
 */
`timescale 1ns/1ps
`default_nettype none

module fdc_props
	import fdc_pkg::*;
(
	input logic       clk,
	input logic       rst,
	input logic       drq,
	input logic       hld,
	input logic       intrq,
	input logic       command_start,
	input logic [7:0] status
);

	// Number of failed properties so far
	int error_count = 0;

	// A byte request only exists inside a running command
	drq_needs_busy: assert property (@(posedge clk) disable iff (rst)
		drq |-> status[st_busy])
		else begin
			error_count++;
			$error("drq is high while the engine is idle");
		end

	// The head is loaded only by a running command
	hld_rise_in_busy: assert property (@(posedge clk) disable iff (rst)
		$rose(hld) |-> status[st_busy])
		else begin
			error_count++;
			$error("hld rose while the engine is idle");
		end

	// A new command clears the interrupt of the previous one
	start_clears_intrq: assert property (@(posedge clk) disable iff (rst)
		command_start |=> !intrq)
		else begin
			error_count++;
			$error("intrq is still high after a command start");
		end

	reset_clears_status: assert property (@(posedge clk)
		rst |=> status == 8'h00)
		else begin
			error_count++;
			$error("status is not zero after reset");
		end

endmodule

bind fdc_sector_cmd fdc_props u_props (
	.clk          (clk),
	.rst          (rst),
	.drq          (drq),
	.hld          (hld),
	.intrq        (intrq),
	.command_start(command_start),
	.status       (status)
);

`default_nettype wire

// File: dv/fdc_tb.sv
/*
 * Testbench for the sector-command controller with its emulated drive.
 * Runs a table of Type II commands and checks status, data bytes,
 * the sector register and the number of bytes the host took.
 */
`timescale 1ns/1ps
`default_nettype none

module fdc_tb
	import fdc_pkg::*;
	import disk_pkg::*;
();

	// How the host serves drq in one row
	localparam logic [1:0] host_prompt = 2'd0;
	localparam logic [1:0] host_lazy   = 2'd1;
	localparam logic [1:0] host_abort  = 2'd2;
	localparam int         row_count   = 14;
	localparam int         wait_limit  = 20000;
	localparam int         clk_period  = 20;
	// One revolution of the emulated track in clk cycles
	localparam int         rev_cycles  =
		sectors_per_track * (gap_bytes + sector_bytes) * byte_cycles;

	typedef struct {
		logic [7:0] cmd;
		logic [7:0] track;
		logic [7:0] sector;
		logic [7:0] head;
		logic       rdy_n;
		logic       wp_n;
		logic [1:0] host;
		logic [7:0] exp_status;
		logic [7:0] exp_sector;
		int         exp_count;
	} row_t;

	logic       clk;
	logic       rst;
	logic       cs;
	logic       we;
	logic [1:0] addr;
	logic [7:0] wdata;
	logic [7:0] rdata;
	logic       ready_n;
	logic       wprot_n;
	logic [7:0] head_track;
	logic       intrq;
	logic       drq;
	logic       hld;
	row_t       rows [row_count];

	fdc_top uut (
		.clk       (clk),
		.rst       (rst),
		.cs        (cs),
		.we        (we),
		.addr      (addr),
		.wdata     (wdata),
		.rdata     (rdata),
		.ready_n   (ready_n),
		.wprot_n   (wprot_n),
		.head_track(head_track),
		.intrq     (intrq),
		.drq       (drq),
		.hld       (hld)
	);

	always #(clk_period / 2) clk = ~clk;

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Simulation FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	// Any failed property on the sector engine ends the run at once
	always @(uut.u_sector.u_props.error_count) begin
		if (uut.u_sector.u_props.error_count != 0)
			stop_run($sformatf("A sector engine property failed at %0t", $time));
	end

	task automatic check_status(input logic [7:0] got, input logic [7:0] exp, input int row);
		if (got !== exp)
			stop_run($sformatf("[ERROR] %0t: row %0d status %02h, expected %02h",
				$time, row, got, exp));
	endtask

	task automatic check_data(input logic [7:0] got, input logic [7:0] exp, input int row,
		input int idx);
		if (got !== exp)
			stop_run($sformatf("[ERROR] %0t: row %0d byte %0d is %02h, expected %02h",
				$time, row, idx, got, exp));
	endtask

	task automatic check_sector(input logic [7:0] got, input logic [7:0] exp, input int row);
		if (got !== exp)
			stop_run($sformatf("[ERROR] %0t: row %0d sector register %0d, expected %0d",
				$time, row, got, exp));
	endtask

	task automatic check_count(input int got, input int exp, input int row);
		if (got != exp)
			stop_run($sformatf("[ERROR] %0t: row %0d host read %0d bytes, expected %0d",
				$time, row, got, exp));
	endtask

	task automatic check_flag(input logic got, input logic exp, input string what,
		input int row);
		if (got !== exp)
			stop_run($sformatf("[ERROR] %0t: row %0d %s is %b, expected %b",
				$time, row, what, got, exp));
	endtask

	// Byte k of sector s on track t in the emulated format
	function automatic logic [7:0] expected_byte(input int track, input int sector, input int k);
		return 8'(16 * sector + k + track);
	endfunction

	// Bus tasks start and end on a falling edge
	task automatic write_reg(input logic [1:0] a, input logic [7:0] v);
		cs    = 1'b1;
		we    = 1'b1;
		addr  = a;
		wdata = v;
		@(posedge clk);
		@(negedge clk);
		cs = 1'b0;
		we = 1'b0;
	endtask

	task automatic read_reg(input logic [1:0] a, output logic [7:0] v);
		cs   = 1'b1;
		we   = 1'b0;
		addr = a;
		// rdata is combinational from addr, so it is settled well before the edge
		#1 v = rdata;
		@(posedge clk);
		@(negedge clk);
		cs = 1'b0;
	endtask

	// pos is the index of the byte that raised the drq just seen
	task automatic take_byte(input int row, input int delay, inout int pos, inout int count);
		int         idx;
		int         last;
		logic [7:0] got;
		// Each whole byte period of delay lets the drive overwrite one more byte
		idx  = pos + delay / byte_cycles;
		last = (pos / sector_bytes) * sector_bytes + sector_bytes - 1;
		if (idx > last)
			idx = last;
		repeat (delay) @(negedge clk);
		read_reg(addr_data, got);
		check_data(got, expected_byte(rows[row].head, rows[row].sector + idx / sector_bytes,
			idx % sector_bytes), row, idx);
		pos = idx + 1;
		count++;
	endtask

	task automatic run_row(input int row);
		logic [7:0] got;
		int         pos;
		int         count;
		int         cycles;
		int         delay;
		int         elapsed;
		time        start;
		bit         done;
		pos        = 0;
		count      = 0;
		cycles     = 0;
		done       = 1'b0;
		head_track = rows[row].head;
		ready_n    = rows[row].rdy_n;
		wprot_n    = rows[row].wp_n;
		write_reg(addr_track, rows[row].track);
		write_reg(addr_sector, rows[row].sector);
		write_reg(addr_cmd_status, rows[row].cmd);
		start = $time;
		read_reg(addr_cmd_status, got);
		check_flag(got[st_busy], 1'b1, "busy after the command write", row);
		while (!done) begin
			if (intrq) begin
				done = 1'b1;
			end else begin
				if (drq && rows[row].host == host_abort) begin
					write_reg(addr_cmd_status, cmd_force_int);
					check_flag(intrq, 1'b1, "intrq after force interrupt", row);
					check_flag(drq, 1'b0, "drq after force interrupt", row);
					done = 1'b1;
				end else if (drq) begin
					delay = 0;
					// A slow host always misses at least one byte period
					if (rows[row].host == host_lazy)
						delay = byte_cycles + int'($urandom % byte_cycles);
					take_byte(row, delay, pos, count);
				end else begin
					@(negedge clk);
				end
				// Every pass takes at least one clock
				cycles++;
				if (cycles > wait_limit)
					stop_run($sformatf("Timeout: row %0d never raised intrq", row));
			end
		end
		elapsed = int'(($time - start) / clk_period);
		check_count(count, rows[row].exp_count, row);
		read_reg(addr_cmd_status, got);
		check_status(got, rows[row].exp_status, row);
		read_reg(addr_sector, got);
		check_sector(got, rows[row].exp_sector, row);
		// Counting the index limit of pulses spans all but one of those revolutions
		if (rows[row].exp_status[st_rnf])
			check_flag(elapsed >= (index_limit - 1) * rev_cycles, 1'b1,
				"search lasting the index limit", row);
		// A command that found the drive ready has loaded the head
		if (!rows[row].rdy_n && rows[row].host != host_abort)
			check_flag(hld, 1'b1, "hld", row);
	endtask

	initial begin
		clk        = 1'b0;
		rst        = 1'b1;
		cs         = 1'b0;
		we         = 1'b0;
		addr       = 2'd0;
		wdata      = 8'h00;
		ready_n    = 1'b1;
		wprot_n    = 1'b1;
		head_track = 8'd0;
		void'($urandom(32'h971c));
		// Command, track, sector, head, ready_n, wprot_n, host, status, sector, bytes
		rows[0]  = '{8'h80, 8'd2, 8'd1, 8'd2, 1'b0, 1'b1, host_prompt, 8'h00, 8'd1, 16};
		rows[1]  = '{8'h80, 8'd2, 8'd3, 8'd2, 1'b0, 1'b1, host_prompt, 8'h00, 8'd3, 16};
		rows[2]  = '{8'h84, 8'd2, 8'd5, 8'd2, 1'b0, 1'b1, host_prompt, 8'h00, 8'd5, 16};
		rows[3]  = '{8'h88, 8'd2, 8'd1, 8'd2, 1'b0, 1'b1, host_prompt, 8'h00, 8'd1, 16};
		rows[4]  = '{8'h88, 8'd2, 8'd3, 8'd2, 1'b0, 1'b1, host_prompt, 8'h00, 8'd3, 16};
		rows[5]  = '{8'h8C, 8'd2, 8'd5, 8'd2, 1'b0, 1'b1, host_prompt, 8'h00, 8'd5, 16};
		// Drive not ready, then record not found for a bad sector and a bad track
		rows[6]  = '{8'h80, 8'd2, 8'd1, 8'd2, 1'b1, 1'b1, host_prompt, 8'h80, 8'd1, 0};
		rows[7]  = '{8'h80, 8'd2, 8'd7, 8'd2, 1'b0, 1'b1, host_prompt, 8'h10, 8'd7, 0};
		rows[8]  = '{8'h80, 8'd3, 8'd2, 8'd2, 1'b0, 1'b1, host_prompt, 8'h10, 8'd2, 0};
		rows[9]  = '{8'hA0, 8'd2, 8'd2, 8'd2, 1'b0, 1'b0, host_prompt, 8'h40, 8'd2, 0};
		rows[10] = '{8'hA0, 8'd2, 8'd2, 8'd2, 1'b0, 1'b1, host_prompt, 8'h00, 8'd2, 0};
		rows[11] = '{8'h80, 8'd2, 8'd3, 8'd2, 1'b0, 1'b1, host_lazy,   8'h04, 8'd3, 8};
		// Multiple sectors run off the end of the track
		rows[12] = '{8'h90, 8'd2, 8'd4, 8'd2, 1'b0, 1'b1, host_prompt, 8'h10, 8'd6, 32};
		rows[13] = '{8'h80, 8'd2, 8'd3, 8'd2, 1'b0, 1'b1, host_abort,  8'h00, 8'd3, 0};
		repeat (8) @(negedge clk);
		rst = 1'b0;
		// The head starts unloaded
		check_flag(hld, 1'b0, "hld after reset", -1);
		for (int i = 0; i < row_count; i++)
			run_row(i);
		$display("Simulation PASSED");
		$finish;
	end

endmodule

`default_nettype wire

// File: filelist.f
src/fdc_pkg.sv
src/disk_pkg.sv
src/fdc_timebase.sv
src/fdc_host_regs.sv
src/fdc_sector_cmd.sv
src/disk_stream.sv
src/fdc_top.sv
dv/fdc_props.sv
dv/fdc_tb.sv

// File: Bender.yml
package:
  name: fdc_sector

sources:
  - target: rtl
    files:
      - src/fdc_pkg.sv
      - src/disk_pkg.sv
      - src/fdc_timebase.sv
      - src/fdc_host_regs.sv
      - src/fdc_sector_cmd.sv
      - src/disk_stream.sv
      - src/fdc_top.sv
  - target: test
    files:
      - dv/fdc_props.sv
      - dv/fdc_tb.sv
